// File: Bender.yml
package:
  name: map_buf

sources:
  - include_dirs:
      - .
    files:
      - map_buf_pkg.sv
      - map_bank_if.sv
      - map_bank_fifo.sv
      - map_wr_ctrl.sv
      - map_rd_mux.sv
      - map_buf_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_map_buf.sv

// File: all.f
+incdir+.
map_buf_pkg.sv
map_bank_if.sv
map_bank_fifo.sv
map_wr_ctrl.sv
map_rd_mux.sv
map_buf_top.sv
tb_map_buf.sv

// File: map_bank_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "map_buf_config.svh"

module map_bank_fifo (
  input  logic     clk,
  input  logic     rstn,
  map_bank_if.fifo bank
);

  localparam int DEPTH = `MAP_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [`MAP_DATA_WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0]           wr_ptr;
  logic [PTR_W-1:0]           rd_ptr;
  logic [CNT_W-1:0]           count;
  logic                       full;
  logic                       empty;
  logic                       do_wr;
  logic                       do_rd;

  // wrap at DEPTH, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full  = (count == CNT_W'(DEPTH));
  assign empty = (count == '0);
  assign do_wr = bank.wr_valid && !full;
  assign do_rd = bank.rd_ready && !empty;

  assign bank.wr_ready = !full;
  assign bank.rd_valid = !empty;     // first word falls through
  assign bank.rd_data  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= bank.wr_data;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (bank.flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= ptr_inc(wr_ptr);
      if (do_rd) rd_ptr <= ptr_inc(rd_ptr);
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // writer only offers a block to a bank the reader has emptied
  a_no_wr_full: assert property (@(posedge clk) disable iff (!rstn)
    full |-> !bank.wr_valid);

  // reader only drains a bank holding a complete block
  a_no_rd_empty: assert property (@(posedge clk) disable iff (!rstn || bank.flush)
    empty |-> !bank.rd_ready);

endmodule

`default_nettype wire

// File: map_bank_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "map_buf_config.svh"

interface map_bank_if;

  // write side, writer to FIFO
  logic                       wr_valid;
  logic                       wr_ready;
  logic [`MAP_DATA_WIDTH-1:0] wr_data;

  // read side, FIFO to read mux
  logic                       rd_valid;
  logic                       rd_ready;
  logic [`MAP_DATA_WIDTH-1:0] rd_data;

  logic                       flush; // empties the bank, one cycle

  modport wr (
    output wr_valid, wr_data, flush,
    input  wr_ready
  );

  modport rd (
    input  rd_valid, rd_data, flush,
    output rd_ready
  );

  modport fifo (
    input  wr_valid, wr_data, rd_ready, flush,
    output wr_ready, rd_valid, rd_data
  );

endinterface

`default_nettype wire

// File: map_buf_config.svh
`ifndef MAP_BUF_CONFIG_SVH
`define MAP_BUF_CONFIG_SVH

// map word width in bits
`define MAP_DATA_WIDTH 32

// words per block, one block fills one bank
`define MAP_BLOCK_WORDS 16

// blocks per frame
// kept odd so the last block of a frame lands in bank A
`define MAP_BLOCK_NUM 5

// bank FIFO depth, must hold a full block
`define MAP_FIFO_DEPTH 16

// settle time after reset or soft reset
`define MAP_INIT_CYCLES 50

// cycles from the detected finish edge to the bank flush
`define MAP_FINISH_DELAY 10

`endif

// File: map_buf_pkg.sv
`default_nettype none

package map_buf_pkg;

  // bank select code shared by writer and read mux
  typedef enum logic [1:0] {
    BANK_NONE = 2'd0, // nothing selected
    BANK_A    = 2'd1,
    BANK_B    = 2'd2
  } bank_id_e;

  // writer FSM states
  typedef enum logic [2:0] {
    INIT,    // settle after reset
    IDLE,    // wait for gdc start edge
    WRITE_A,
    WRITE_B,
    WAIT_A,  // bank A full, wait for reader
    WAIT_B
  } wr_state_e;

endpackage

`default_nettype wire

// File: map_buf_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "map_buf_config.svh"

module map_buf_top
  import map_buf_pkg::*;
(
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       i_soft_rstn,
  input  logic                       i_gdc_start,
  input  logic                       i_rd_finish,
  // map word stream in
  input  logic                       i_s_valid,
  output logic                       o_s_ready,
  input  logic [`MAP_DATA_WIDTH-1:0] i_s_data,
  // merged stream out
  output logic                       o_m_valid,
  input  logic                       i_m_ready,
  output logic [`MAP_DATA_WIDTH-1:0] o_m_data,
  output logic                       o_rd_start
);

  logic     blk_done;
  bank_id_e blk_bank;
  bank_id_e rd_bank;

  map_bank_if bank_a_if ();
  map_bank_if bank_b_if ();

  map_bank_fifo u_bank_a (.clk(clk), .rstn(rstn), .bank(bank_a_if));
  map_bank_fifo u_bank_b (.clk(clk), .rstn(rstn), .bank(bank_b_if));

  map_wr_ctrl u_wr_ctrl (
    .clk         (clk),
    .rstn        (rstn),
    .i_soft_rstn (i_soft_rstn),
    .i_gdc_start (i_gdc_start),
    .i_rd_finish (i_rd_finish),
    .i_s_valid   (i_s_valid),
    .i_s_data    (i_s_data),
    .i_rd_bank   (rd_bank),
    .o_s_ready   (o_s_ready),
    .bank_a      (bank_a_if),
    .bank_b      (bank_b_if),
    .o_blk_done  (blk_done),
    .o_blk_bank  (blk_bank),
    .o_rd_start  (o_rd_start)
  );

  map_rd_mux u_rd_mux (
    .clk        (clk),
    .rstn       (rstn),
    .bank_a     (bank_a_if),
    .bank_b     (bank_b_if),
    .i_blk_done (blk_done),
    .i_blk_bank (blk_bank),
    .o_rd_bank  (rd_bank),
    .o_m_valid  (o_m_valid),
    .o_m_data   (o_m_data),
    .i_m_ready  (i_m_ready)
  );

endmodule

`default_nettype wire

// File: map_rd_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "map_buf_config.svh"

module map_rd_mux
  import map_buf_pkg::*;
(
  input  logic                       clk,
  input  logic                       rstn,
  map_bank_if.rd                     bank_a,
  map_bank_if.rd                     bank_b,
  input  logic                       i_blk_done,
  input  bank_id_e                   i_blk_bank,
  output bank_id_e                   o_rd_bank,
  output logic                       o_m_valid,
  output logic [`MAP_DATA_WIDTH-1:0] o_m_data,
  input  logic                       i_m_ready
);

  localparam int CNT_W = $clog2(`MAP_BLOCK_WORDS + 1);

  bank_id_e         sel_q;
  bank_id_e         sel_d;
  bank_id_e         next_q;  // next bank in the A/B alternation
  bank_id_e         other;
  logic             rdy_a;   // bank holds a complete block
  logic             rdy_b;
  logic             next_rdy;
  logic             other_rdy;
  logic             take_a;
  logic             take_b;
  logic             flush;
  logic             m_fire;
  logic             blk_end;
  logic [CNT_W-1:0] rd_cnt;

  assign flush     = bank_a.flush || bank_b.flush;
  assign other     = (sel_q == BANK_A) ? BANK_B : BANK_A;
  assign next_rdy  = (next_q == BANK_B) ? rdy_b : rdy_a;
  assign other_rdy = (other == BANK_B) ? rdy_b : rdy_a;
  assign m_fire    = o_m_valid && i_m_ready;
  assign blk_end   = m_fire && (rd_cnt == CNT_W'(`MAP_BLOCK_WORDS - 1));

  ////////////////////////////////////////
  // bank select
  ////////////////////////////////////////
  always_comb begin
    sel_d = sel_q;
    if (sel_q == BANK_NONE) begin
      if (next_rdy) sel_d = next_q;
    end else if (blk_end) begin
      sel_d = other_rdy ? other : BANK_NONE; // hop straight over if waiting
    end
  end

  assign take_a = (sel_d == BANK_A) && (sel_q != BANK_A);
  assign take_b = (sel_d == BANK_B) && (sel_q != BANK_B);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      sel_q  <= BANK_NONE;
      next_q <= BANK_A;
      rdy_a  <= 1'b0;
      rdy_b  <= 1'b0;
      rd_cnt <= '0;
    end else if (flush) begin
      sel_q  <= BANK_NONE;
      next_q <= BANK_A;     // a new frame starts in bank A
      rdy_a  <= 1'b0;
      rdy_b  <= 1'b0;
      rd_cnt <= '0;
    end else begin
      sel_q <= sel_d;
      rdy_a <= (rdy_a && !take_a) || (i_blk_done && i_blk_bank == BANK_A);
      rdy_b <= (rdy_b && !take_b) || (i_blk_done && i_blk_bank == BANK_B);
      if (take_a)      next_q <= BANK_B;
      else if (take_b) next_q <= BANK_A;
      if (blk_end)     rd_cnt <= '0;
      else if (m_fire) rd_cnt <= rd_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////
  // output mux
  ////////////////////////////////////////
  assign o_rd_bank       = sel_q;
  assign bank_a.rd_ready = (sel_q == BANK_A) && i_m_ready;
  assign bank_b.rd_ready = (sel_q == BANK_B) && i_m_ready;

  always_comb begin
    case (sel_q)
      BANK_A: begin
        o_m_valid = bank_a.rd_valid;
        o_m_data  = bank_a.rd_data;
      end
      BANK_B: begin
        o_m_valid = bank_b.rd_valid;
        o_m_data  = bank_b.rd_data;
      end
      default: begin
        o_m_valid = 1'b0;
        o_m_data  = '0;
      end
    endcase
  end

  // a selected bank keeps a word ready until its block is out
  a_sel_has_data: assert property (@(posedge clk) disable iff (!rstn)
    (o_rd_bank != BANK_NONE) |-> o_m_valid);

endmodule

`default_nettype wire

// File: map_wr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "map_buf_config.svh"

module map_wr_ctrl
  import map_buf_pkg::*;
(
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       i_soft_rstn,
  input  logic                       i_gdc_start,
  input  logic                       i_rd_finish,
  input  logic                       i_s_valid,
  input  logic [`MAP_DATA_WIDTH-1:0] i_s_data,
  input  bank_id_e                   i_rd_bank,
  output logic                       o_s_ready,
  map_bank_if.wr                     bank_a,
  map_bank_if.wr                     bank_b,
  output logic                       o_blk_done,
  output bank_id_e                   o_blk_bank,
  output logic                       o_rd_start
);

  localparam int INIT_W = $clog2(`MAP_INIT_CYCLES + 1);
  localparam int WORD_W = $clog2(`MAP_BLOCK_WORDS + 1);
  localparam int BLK_W  = $clog2(`MAP_BLOCK_NUM + 1);
  localparam int FIN_W  = $clog2(`MAP_FINISH_DELAY + 1);

  wr_state_e         state_q;
  wr_state_e         state_d;
  logic [1:0]        sync_q0;   // bit 0 start and bit 1 finish
  logic [1:0]        sync_q1;
  logic [1:0]        sync_q2;
  logic              start_edge;
  logic              fin_edge;
  logic [INIT_W-1:0] init_cnt;
  logic              init_done;
  logic [FIN_W-1:0]  fin_cnt;
  logic              fin_busy;
  logic              fin_fire;
  logic              flush;
  logic [WORD_W-1:0] wr_cnt;
  logic [BLK_W-1:0]  blk_cnt;
  logic              frame_full;
  logic              s_fire;
  logic              last_word;

  ////////////////////////////////////////
  // edge detect, init settle, finish delay
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      sync_q0 <= '0;
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q0 <= {i_rd_finish, i_gdc_start};
      sync_q1 <= sync_q0;
      sync_q2 <= sync_q1; // history for rise detect
    end
  end

  assign start_edge = sync_q1[0] & ~sync_q2[0];
  assign fin_edge   = sync_q1[1] & ~sync_q2[1];

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      init_cnt <= '0;
    end else if (!i_soft_rstn) begin
      init_cnt <= '0;             // settle again
    end else if (!init_done) begin
      init_cnt <= init_cnt + 1'b1;
    end
  end

  assign init_done = (init_cnt == INIT_W'(`MAP_INIT_CYCLES - 1));

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      fin_busy <= 1'b0;
      fin_cnt  <= '0;
    end else if (!i_soft_rstn) begin
      fin_busy <= 1'b0;
      fin_cnt  <= '0;
    end else if (fin_edge) begin
      fin_busy <= 1'b1;
      fin_cnt  <= '0;
    end else if (fin_fire) begin
      fin_busy <= 1'b0;
    end else if (fin_busy) begin
      fin_cnt <= fin_cnt + 1'b1;
    end
  end

  assign fin_fire = fin_busy && (fin_cnt == FIN_W'(`MAP_FINISH_DELAY - 1));
  assign flush    = fin_fire || !i_soft_rstn;

  ////////////////////////////////////////
  // block and frame counters
  ////////////////////////////////////////
  assign s_fire     = i_s_valid && o_s_ready;
  assign last_word  = s_fire && (wr_cnt == WORD_W'(`MAP_BLOCK_WORDS - 1));
  assign frame_full = (blk_cnt == BLK_W'(`MAP_BLOCK_NUM));

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_cnt  <= '0;
      blk_cnt <= '0;
    end else if (flush || state_q == IDLE || state_q == INIT) begin
      wr_cnt  <= '0;
      blk_cnt <= '0;
    end else if (last_word) begin
      wr_cnt  <= '0;
      blk_cnt <= blk_cnt + 1'b1;
    end else if (s_fire) begin
      wr_cnt <= wr_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////
  // writer FSM
  ////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      INIT:    if (init_done) state_d = IDLE;
      IDLE:    if (start_edge) state_d = WRITE_A;
      WRITE_A: if (last_word) state_d = WAIT_A;
      WRITE_B: if (last_word) state_d = WAIT_B;
      // move on once the reader has taken the bank just filled
      WAIT_A:  if (!frame_full && i_rd_bank == BANK_A) state_d = WRITE_B;
      WAIT_B:  if (!frame_full && i_rd_bank == BANK_B) state_d = WRITE_A;
      default: state_d = INIT;
    endcase
    if (!i_soft_rstn) begin
      state_d = INIT;
    end else if (fin_fire && state_q != INIT) begin
      state_d = IDLE;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) state_q <= INIT;
    else       state_q <= state_d;
  end

  assign o_s_ready = !frame_full && ((state_q == WRITE_A && bank_a.wr_ready) ||
                                     (state_q == WRITE_B && bank_b.wr_ready));

  assign bank_a.wr_valid = (state_q == WRITE_A) && !frame_full && i_s_valid;
  assign bank_b.wr_valid = (state_q == WRITE_B) && !frame_full && i_s_valid;
  assign bank_a.wr_data  = i_s_data;
  assign bank_b.wr_data  = i_s_data;
  assign bank_a.flush    = flush;
  assign bank_b.flush    = flush;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      o_blk_done <= 1'b0;
      o_blk_bank <= BANK_NONE;
    end else begin
      o_blk_done <= last_word && !flush;
      if (last_word) o_blk_bank <= (state_q == WRITE_B) ? BANK_B : BANK_A;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      o_rd_start <= 1'b0;
    end else if (start_edge || fin_edge || !i_soft_rstn) begin
      o_rd_start <= 1'b0;
    end else if (last_word) begin
      o_rd_start <= 1'b1; // first full block in the frame
    end
  end

  // the bank open for input is never the one being drained
  a_wr_bank_not_read: assert property (@(posedge clk) disable iff (!rstn)
    o_s_ready |-> ((state_q == WRITE_A) ? (i_rd_bank != BANK_A) : (i_rd_bank != BANK_B)));

  // a bank is refilled only after the read mux has started on it
  property p_done_then_read(bank_id_e b);
    @(posedge clk) disable iff (!rstn || flush)
      (o_blk_done && o_blk_bank == b) |=>
        ((!(o_blk_done && o_blk_bank == b)) until (i_rd_bank == b));
  endproperty

  a_done_read_a: assert property (p_done_then_read(BANK_A));
  a_done_read_b: assert property (p_done_then_read(BANK_B));

endmodule

`default_nettype wire

// File: tb_map_buf.sv
`timescale 1ns/1ps
`default_nettype none

`include "map_buf_config.svh"

module tb_map_buf;

  localparam int FRAME_WORDS = `MAP_BLOCK_NUM * `MAP_BLOCK_WORDS;
  localparam int BUF_LIMIT   = 2 * `MAP_BLOCK_WORDS;
  localparam int WAIT_LIMIT  = FRAME_WORDS * 40;

  logic                       clk;
  logic                       rstn;
  logic                       i_soft_rstn;
  logic                       i_gdc_start;
  logic                       i_rd_finish;
  logic                       i_s_valid;
  logic                       o_s_ready;
  logic [`MAP_DATA_WIDTH-1:0] i_s_data;
  logic                       o_m_valid;
  logic                       i_m_ready;
  logic [`MAP_DATA_WIDTH-1:0] o_m_data;
  logic                       o_rd_start;

  logic [31:0]                lcg_state;
  int                         ready_thr;   // sink ready chance in 16ths
  logic [`MAP_DATA_WIDTH-1:0] sb_q[$];     // accepted and not yet delivered
  logic [`MAP_DATA_WIDTH-1:0] exp_head;
  logic                       exp_avail;
  logic [`MAP_DATA_WIDTH-1:0] last_m_data;
  int unsigned                accepted;
  int unsigned                delivered;
  int unsigned                frame_words;
  logic                       frame_open;  // start given and words still due
  logic                       blk_seen;    // a full block went in this frame
  logic                       settling;    // reset or soft reset settle window

  map_buf_top u_map_buf_top (
    .clk         (clk),
    .rstn        (rstn),
    .i_soft_rstn (i_soft_rstn),
    .i_gdc_start (i_gdc_start),
    .i_rd_finish (i_rd_finish),
    .i_s_valid   (i_s_valid),
    .o_s_ready   (o_s_ready),
    .i_s_data    (i_s_data),
    .o_m_valid   (o_m_valid),
    .i_m_ready   (i_m_ready),
    .o_m_data    (o_m_data),
    .o_rd_start  (o_rd_start)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  ////////////////////////////////////////
  // stream driver and scoreboard
  ////////////////////////////////////////
  always @(posedge clk) begin : stream_drive
    logic        took;
    logic [31:0] r;
    took = i_s_valid && o_s_ready;  // pre-edge handshake
    #2;
    if (rstn) begin
      // a word stays offered until it is taken
      if (took || !i_s_valid) begin
        r = lcg_next();
        i_s_valid = (r[31:28] < 4'd12);
        i_s_data  = lcg_next();
      end
      r = lcg_next();
      i_m_ready = (int'(r[31:28]) < ready_thr);
    end
  end

  always @(posedge clk) begin : scoreboard
    if (rstn) begin
      if (o_m_valid && i_m_ready) begin
        if (sb_q.size() != 0) sb_q.delete(0);
        delivered <= delivered + 1;
      end
      if (i_s_valid && o_s_ready) begin
        sb_q.push_back(i_s_data);
        accepted    <= accepted + 1;
        frame_words <= frame_words + 1;
        if (frame_words + 1 >= `MAP_BLOCK_WORDS) blk_seen <= 1'b1;
        if (frame_words + 1 == FRAME_WORDS) frame_open <= 1'b0;
      end
      exp_avail   <= (sb_q.size() != 0);
      exp_head    <= (sb_q.size() != 0) ? sb_q[0] : '0;
      last_m_data <= o_m_data;
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////
  a_settle_quiet: assert property (@(posedge clk) disable iff (!rstn)
    settling |-> !o_s_ready && !o_m_valid && !o_rd_start)
    else report_fail($sformatf(
      "CHECK FAILED o_s_ready/o_m_valid/o_rd_start got %h %h %h expected 0 0 0",
      $sampled(o_s_ready), $sampled(o_m_valid), $sampled(o_rd_start)));

  // ready must stay low outside an open frame, which bounds the frame length
  a_ready_in_frame: assert property (@(posedge clk) disable iff (!rstn)
    !frame_open |-> !o_s_ready)
    else report_fail($sformatf("CHECK FAILED o_s_ready got %h expected %h",
                               $sampled(o_s_ready), 1'b0));

  a_out_known: assert property (@(posedge clk) disable iff (!rstn)
    (o_m_valid && i_m_ready) |-> exp_avail)
    else report_fail("output word delivered while no accepted word was pending");

  a_out_data: assert property (@(posedge clk) disable iff (!rstn)
    (o_m_valid && i_m_ready && exp_avail) |-> (o_m_data == exp_head))
    else report_fail($sformatf("CHECK FAILED o_m_data got %h expected %h",
                               $sampled(o_m_data), $sampled(exp_head)));

  a_hold_valid: assert property (@(posedge clk) disable iff (!rstn || !i_soft_rstn)
    (o_m_valid && !i_m_ready) |=> o_m_valid)
    else report_fail($sformatf("CHECK FAILED o_m_valid got %h expected %h",
                               $sampled(o_m_valid), 1'b1));

  a_hold_data: assert property (@(posedge clk) disable iff (!rstn || !i_soft_rstn)
    (o_m_valid && !i_m_ready) |=> (o_m_data == last_m_data))
    else report_fail($sformatf("CHECK FAILED o_m_data got %h expected %h",
                               $sampled(o_m_data), $sampled(last_m_data)));

  a_buf_bound: assert property (@(posedge clk) disable iff (!rstn)
    (accepted - delivered) <= BUF_LIMIT)
    else report_fail($sformatf("CHECK FAILED words in flight got %h limit %h",
                               $sampled(accepted - delivered), BUF_LIMIT));

  a_rd_start: assert property (@(posedge clk) disable iff (!rstn)
    blk_seen |-> o_rd_start)
    else report_fail($sformatf("CHECK FAILED o_rd_start got %h expected %h",
                               $sampled(o_rd_start), 1'b1));

  ////////////////////////////////////////
  // sequence tasks
  ////////////////////////////////////////
  task automatic pulse_start(input bit open_frame);
    @(posedge clk);
    #2;
    i_gdc_start = 1'b1;
    if (open_frame) begin
      frame_words = 0;
      blk_seen    = 1'b0;
      frame_open  = 1'b1;
    end
    repeat (2) @(posedge clk);
    #2;
    i_gdc_start = 1'b0;
  endtask

  task automatic pulse_finish();
    @(posedge clk);
    #2;
    i_rd_finish = 1'b1;
    blk_seen    = 1'b0;
    repeat (2) @(posedge clk);
    #2;
    i_rd_finish = 1'b0;
    repeat (`MAP_FINISH_DELAY + 4) @(posedge clk); // flush lands in here
  endtask

  task automatic wait_frame_in(input int limit);
    int n;
    n = 0;
    while (frame_open) begin
      @(negedge clk);
      n++;
      if (n > limit) report_fail("timeout while waiting for the frame input to complete");
    end
  endtask

  task automatic wait_drained(input int limit);
    int n;
    n = 0;
    while (delivered != accepted) begin
      @(negedge clk);
      n++;
      if (n > limit) report_fail("timeout while waiting for the buffer to drain");
    end
  endtask

  task automatic run_frame(input int thr);
    ready_thr = thr;
    pulse_start(1'b1);
    wait_frame_in(WAIT_LIMIT);
    wait_drained(WAIT_LIMIT);
    pulse_finish();
  endtask

  task automatic soft_reset();
    @(posedge clk);
    #2;
    i_soft_rstn = 1'b0;
    frame_open  = 1'b0;
    blk_seen    = 1'b0;
    @(posedge clk);
    #2;
    settling = 1'b1;  // quiet from one edge in
    repeat (3) @(posedge clk);
    #2;
    i_soft_rstn = 1'b1;
    repeat (`MAP_INIT_CYCLES + 10) @(posedge clk);
    #2;
    settling = 1'b0;
  endtask

  initial begin : main_seq
    clk         = 1'b0;
    rstn        = 1'b0;
    i_soft_rstn = 1'b1;
    i_gdc_start = 1'b0;
    i_rd_finish = 1'b0;
    i_s_valid   = 1'b0;
    i_s_data    = '0;
    i_m_ready   = 1'b0;
    lcg_state   = 32'hc648;
    ready_thr   = 12;
    exp_head    = '0;
    exp_avail   = 1'b0;
    last_m_data = '0;
    accepted    = 0;
    delivered   = 0;
    frame_words = 0;
    frame_open  = 1'b0;
    blk_seen    = 1'b0;
    settling    = 1'b1;

    repeat (8) @(posedge clk);
    #2;
    rstn = 1'b1;
    repeat (10) @(posedge clk);
    pulse_start(1'b0);  // too early as the writer is still settling
    repeat (`MAP_INIT_CYCLES + 20) @(posedge clk);
    #2;
    settling = 1'b0;

    run_frame(12);  // mild output gaps
    run_frame(3);   // slow sink so the writer stalls on full banks
    soft_reset();
    run_frame(16);  // sink always ready

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire
